/* bench/hysteresis_props.sv */
`timescale 1ns/100ps

module hysteresis_props (
    input logic clock,
    input logic reset,
    input logic in_rd_en,
    input logic in_empty,
    input logic out_wr_en,
    input logic out_full,
    input logic frame_done,
    input logic class_valid,
    input logic neighbor_valid
);

    // Input FIFO strobe
    read_while_empty: assert property (@(posedge clock) disable iff (reset)
        !(in_rd_en && in_empty))
        else $error("in_rd_en high while input FIFO is empty");

    // Output FIFO strobe
    write_while_full: assert property (@(posedge clock) disable iff (reset)
        !(out_wr_en && out_full))
        else $error("out_wr_en high while output FIFO is full");

    done_without_write: assert property (@(posedge clock) disable iff (reset)
        frame_done |-> out_wr_en)
        else $error("frame_done high without out_wr_en");

    // The merge expects both raters in lock step
    raters_in_step: assert property (@(posedge clock) disable iff (reset)
        class_valid == neighbor_valid)
        else $error("class_valid and neighbor_valid differ");

endmodule

/* bench/hysteresis_tb.sv */
`timescale 1ns/100ps
`include "edge_settings.svh"

module hysteresis_tb;
    import pixel_pkg::*;
    import frame_pkg::*;

    localparam int width = `EDGE_WIDTH;
    localparam int height = `EDGE_HEIGHT;
    localparam int frame_pixels = width * height;
    localparam int frames = 3;
    localparam int total_pixels = frames * frame_pixels;
    // Ten cycles of 10 ns per pixel, plus margin for reset and the last frame
    localparam int watchdog_ns = frames * frame_pixels * 10 * 10 + 1000;

    logic    clock = 1'b0;
    logic    reset;
    logic    in_rd_en;
    logic    in_empty;
    pixel_t  in_dout;
    logic    out_wr_en;
    logic    out_full;
    pixel_t  out_din;
    logic    frame_done;

    integer  seed = 82534;
    int      reset_cycles = 0;
    int      rd_ptr = 0;
    int      out_count = 0;
    pixel_t  pixels [0:total_pixels-1];

    hysteresis_top i_dut (
        .clock      (clock),
        .reset      (reset),
        .in_rd_en   (in_rd_en),
        .in_empty   (in_empty),
        .in_dout    (in_dout),
        .out_wr_en  (out_wr_en),
        .out_full   (out_full),
        .out_din    (out_din),
        .frame_done (frame_done)
    );

    bind hysteresis_top hysteresis_props props (
        .clock          (clock),
        .reset          (reset),
        .in_rd_en       (in_rd_en),
        .in_empty       (in_empty),
        .out_wr_en      (out_wr_en),
        .out_full       (out_full),
        .frame_done     (frame_done),
        .class_valid    (class_valid),
        .neighbor_valid (neighbor_valid)
    );

    always #5 clock = ~clock;

    function automatic pixel_t pixel_at(input int frame, input int row, input int col);
        return pixels[frame * frame_pixels + row * width + col];
    endfunction

    // Hysteresis rule: strong passes, weak needs a strong neighbour, border is zero
    function automatic pixel_t expected_pixel(input int frame, input int row, input int col);
        pixel_t center;
        logic   strong_near;
        int     dr;
        int     dc;
        if (row == 0 || row == height - 1 || col == 0 || col == width - 1) begin
            return '0;
        end
        center = pixel_at(frame, row, col);
        if (center > `EDGE_HIGH_THRESHOLD) begin
            return center;
        end
        if (center <= `EDGE_LOW_THRESHOLD) begin
            return '0;
        end
        strong_near = 1'b0;
        for (dr = -1; dr <= 1; dr++) begin
            for (dc = -1; dc <= 1; dc++) begin
                if ((dr != 0 || dc != 0) &&
                    pixel_at(frame, row + dr, col + dc) > `EDGE_HIGH_THRESHOLD) begin
                    strong_near = 1'b1;
                end
            end
        end
        return strong_near ? center : '0;
    endfunction

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t want,
                               input int frame, input int row, input int col);
        if (got !== want) begin
            $display("ERR %s got 0x%h expected 0x%h at frame %0d row %0d col %0d",
                     name, got, want, frame, row, col);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_frame_done(input string name, input logic got, input logic want,
                                    input int frame, input int row, input int col);
        if (got !== want) begin
            $display("ERR %s got 0x%h expected 0x%h at frame %0d row %0d col %0d",
                     name, got, want, frame, row, col);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    initial begin
        reset = 1'b1;
        in_empty = 1'b1;
        in_dout = '0;
        out_full = 1'b0;
        // Random magnitudes around both limits, with exact limit values planted
        for (int i = 0; i < total_pixels; i++) begin
            pixels[i] = pixel_t'($unsigned($random(seed)) % 72);
            if (i % 11 == 3) begin
                pixels[i] = pixel_t'(`EDGE_HIGH_THRESHOLD);
            end else if (i % 13 == 5) begin
                pixels[i] = pixel_t'(`EDGE_LOW_THRESHOLD);
            end
        end
    end

    // Reset sequence and random FIFO status, all on the falling edge
    always @(negedge clock) begin
        if (reset) begin
            reset_cycles <= reset_cycles + 1;
            if (reset_cycles == 15) begin
                reset <= 1'b0;
            end
            in_empty <= 1'b1;
            out_full <= 1'b0;
        end else begin
            in_empty <= (rd_ptr >= total_pixels) || ($unsigned($random(seed)) % 3 == 0);
            in_dout <= (rd_ptr < total_pixels) ? pixels[rd_ptr] : '0;
            out_full <= ($unsigned($random(seed)) % 3 == 0);
        end
    end

    // Input FIFO pops on each accepted read
    always @(posedge clock) begin
        if (!reset && in_rd_en) begin
            rd_ptr <= rd_ptr + 1;
        end
    end

    always @(posedge clock) begin : compare
        int frame;
        int row;
        int col;
        if (!reset && out_wr_en) begin
            if (out_count >= total_pixels) begin
                $display("Output FIFO written again after the last expected pixel");
                $display("TEST RESULT: FAIL");
                $fatal(1, "extra output write");
            end else begin
                frame = out_count / frame_pixels;
                row = (out_count % frame_pixels) / width;
                col = out_count % width;
                check_pixel("out_din", out_din, expected_pixel(frame, row, col),
                            frame, row, col);
                check_frame_done("frame_done", frame_done,
                                 (row == height - 1) && (col == width - 1), frame, row, col);
                out_count <= out_count + 1;
            end
        end
    end

    initial begin
        wait (out_count == total_pixels);
        // Stay a while to catch any stray write
        repeat (4 * width) @(posedge clock);
        if (rd_ptr == total_pixels) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("Input FIFO not drained, %0d of %0d pixels read", rd_ptr, total_pixels);
            $display("TEST RESULT: FAIL");
            $fatal(1, "input not consumed");
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Output stalled, only %0d of %0d pixels written before timeout",
                 out_count, total_pixels);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

/* source/edge_settings.svh */
`ifndef EDGE_SETTINGS_SVH
`define EDGE_SETTINGS_SVH

// Image size in pixels
`define EDGE_WIDTH 16
`define EDGE_HEIGHT 8

// Gradient limits, both compared strictly
`define EDGE_HIGH_THRESHOLD 48
`define EDGE_LOW_THRESHOLD 12

`endif

/* source/frame_pkg.sv */
`include "edge_settings.svh"

package frame_pkg;

    // Position of a pixel inside the frame
    typedef logic [$clog2(`EDGE_WIDTH)-1:0] col_t;
    typedef logic [$clog2(`EDGE_HEIGHT)-1:0] row_t;

    // Last column and last row, used for border and frame end checks
    localparam col_t last_col = col_t'(`EDGE_WIDTH - 1);
    localparam row_t last_row = row_t'(`EDGE_HEIGHT - 1);

endpackage

/* source/hysteresis_merge.sv */
`timescale 1ns/100ps

module hysteresis_merge (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   out_full,
    output logic                   pipe_enable,
    input  logic                   class_valid,
    input  logic                   neighbor_valid,
    input  pixel_pkg::strength_t   center_strength,
    input  pixel_pkg::pixel_t      center_value,
    input  logic                   any_strong_neighbor,
    input  frame_pkg::row_t        win_row,
    input  frame_pkg::col_t        win_col,
    output logic                   out_wr_en,
    output pixel_pkg::pixel_t      out_din,
    output logic                   frame_done
);
    import pixel_pkg::*;
    import frame_pkg::*;

    row_t    pos_row;
    col_t    pos_col;
    pixel_t  result;
    logic    stage_valid;
    logic    on_border;
    logic    keep_pixel;
    logic    at_frame_end;
    logic    out_valid;
    logic    out_last;

    // A full output FIFO freezes every stage
    assign pipe_enable = !out_full;

    // Both raters run in lock step
    assign stage_valid = class_valid && neighbor_valid;

    assign on_border = (pos_row == '0) || (pos_row == last_row) ||
                       (pos_col == '0) || (pos_col == last_col);
    assign keep_pixel = (center_strength == STRENGTH_STRONG) ||
                        ((center_strength == STRENGTH_WEAK) && any_strong_neighbor);
    assign result = (keep_pixel && !on_border) ? center_value : '0;
    assign at_frame_end = (pos_row == last_row) && (pos_col == last_col);

    // Position waits one stage to line up with the ratings
    always_ff @(posedge clock) begin
        if (pipe_enable) begin
            pos_row <= win_row;
            pos_col <= win_col;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_last <= 1'b0;
        end else if (pipe_enable) begin
            out_valid <= stage_valid;
            out_last <= stage_valid && at_frame_end;
        end
    end

    always_ff @(posedge clock) begin
        if (pipe_enable && stage_valid) begin
            out_din <= result;
        end
    end

    // Held result is written in the first cycle the FIFO has room
    assign out_wr_en = out_valid && !out_full;
    assign frame_done = out_last && !out_full;

endmodule

/* source/hysteresis_top.sv */
`timescale 1ns/100ps

module hysteresis_top (
    input  logic                clock,
    input  logic                reset,
    output logic                in_rd_en,
    input  logic                in_empty,
    input  pixel_pkg::pixel_t   in_dout,
    output logic                out_wr_en,
    input  logic                out_full,
    output pixel_pkg::pixel_t   out_din,
    output logic                frame_done
);
    import pixel_pkg::*;
    import frame_pkg::*;

    logic              pipe_enable;

    // Window to raters and merge
    logic              win_valid;
    pixel_t            win_center;
    pixel_t [7:0]      win_neighbors;
    row_t              win_row;
    col_t              win_col;

    // Raters to merge
    logic              class_valid;
    strength_t         center_strength;
    pixel_t            center_value;
    logic              neighbor_valid;
    logic              any_strong_neighbor;

    pixel_window window (
        .clock         (clock),
        .reset         (reset),
        .pipe_enable   (pipe_enable),
        .in_empty      (in_empty),
        .in_dout       (in_dout),
        .in_rd_en      (in_rd_en),
        .win_valid     (win_valid),
        .win_center    (win_center),
        .win_neighbors (win_neighbors),
        .win_row       (win_row),
        .win_col       (win_col)
    );

    strength_classify classify (
        .clock           (clock),
        .reset           (reset),
        .pipe_enable     (pipe_enable),
        .win_valid       (win_valid),
        .win_center      (win_center),
        .class_valid     (class_valid),
        .center_strength (center_strength),
        .center_value    (center_value)
    );

    neighbor_strength neighbors (
        .clock               (clock),
        .reset               (reset),
        .pipe_enable         (pipe_enable),
        .win_valid           (win_valid),
        .win_neighbors       (win_neighbors),
        .neighbor_valid      (neighbor_valid),
        .any_strong_neighbor (any_strong_neighbor)
    );

    hysteresis_merge merge (
        .clock               (clock),
        .reset               (reset),
        .out_full            (out_full),
        .pipe_enable         (pipe_enable),
        .class_valid         (class_valid),
        .neighbor_valid      (neighbor_valid),
        .center_strength     (center_strength),
        .center_value        (center_value),
        .any_strong_neighbor (any_strong_neighbor),
        .win_row             (win_row),
        .win_col             (win_col),
        .out_wr_en           (out_wr_en),
        .out_din             (out_din),
        .frame_done          (frame_done)
    );

endmodule

/* source/neighbor_strength.sv */
`timescale 1ns/100ps
`include "edge_settings.svh"

module neighbor_strength (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     pipe_enable,
    input  logic                     win_valid,
    input  pixel_pkg::pixel_t [7:0]  win_neighbors,
    output logic                     neighbor_valid,
    output logic                     any_strong_neighbor
);
    import pixel_pkg::*;

    localparam pixel_t high_limit = pixel_t'(`EDGE_HIGH_THRESHOLD);

    logic [7:0] strong_hits;

    // One comparator per neighbour
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            strong_hits[i] = win_neighbors[i] > high_limit;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            neighbor_valid <= 1'b0;
        end else if (pipe_enable) begin
            neighbor_valid <= win_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (pipe_enable && win_valid) begin
            any_strong_neighbor <= |strong_hits;
        end
    end

endmodule

/* source/pixel_pkg.sv */
package pixel_pkg;

    // One gradient magnitude
    typedef logic [7:0] pixel_t;

    // Rating of a magnitude against the two limits
    typedef enum logic [1:0] {
        STRENGTH_NONE   = 2'd0,
        STRENGTH_WEAK   = 2'd1,
        STRENGTH_STRONG = 2'd2
    } strength_t;

endpackage

/* source/pixel_window.sv */
`timescale 1ns/100ps
`include "edge_settings.svh"

module pixel_window (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     pipe_enable,
    input  logic                     in_empty,
    input  pixel_pkg::pixel_t        in_dout,
    output logic                     in_rd_en,
    output logic                     win_valid,
    output pixel_pkg::pixel_t        win_center,
    output pixel_pkg::pixel_t [7:0]  win_neighbors,
    output frame_pkg::row_t          win_row,
    output frame_pkg::col_t          win_col
);
    import pixel_pkg::*;
    import frame_pkg::*;

    // Two lines plus three pixels, oldest pixel at index 0
    localparam int buf_len = 2 * `EDGE_WIDTH + 3;
    localparam int fill_len = `EDGE_WIDTH + 2;
    localparam int fill_bits = $clog2(fill_len);
    localparam int mid = `EDGE_WIDTH;

    typedef enum logic [1:0] {
        PROLOGUE,
        STREAM,
        PAD
    } phase_t;

    phase_t                phase;
    logic [fill_bits-1:0]  fill_count;
    row_t                  row;
    col_t                  col;
    pixel_t [0:buf_len-1]  shift_reg;
    pixel_t                shift_data;
    logic                  shift;
    logic                  emit;
    logic                  last_read;
    logic                  last_pad;

    // Reads stop once the frame's last pixel is in, padding needs no input
    assign in_rd_en = pipe_enable && !in_empty && (phase != PAD);
    assign shift = in_rd_en || (pipe_enable && (phase == PAD));
    assign shift_data = (phase == PAD) ? '0 : in_dout;
    assign emit = shift && (phase != PROLOGUE);

    // The window at (H-2, W-3) is the one whose shift takes the last pixel
    assign last_read = (row == row_t'(`EDGE_HEIGHT - 2)) && (col == col_t'(`EDGE_WIDTH - 3));
    assign last_pad = (row == last_row) && (col == last_col);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            phase <= PROLOGUE;
            fill_count <= '0;
            row <= '0;
            col <= '0;
            win_valid <= 1'b0;
        end else if (pipe_enable) begin
            win_valid <= emit;
            case (phase)
                PROLOGUE: begin
                    if (in_rd_en) begin
                        if (fill_count == fill_bits'(fill_len - 1)) begin
                            fill_count <= '0;
                            phase <= STREAM;
                        end else begin
                            fill_count <= fill_count + 1'b1;
                        end
                    end
                end
                STREAM: begin
                    if (in_rd_en && last_read) begin
                        phase <= PAD;
                    end
                end
                PAD: begin
                    if (last_pad) begin
                        phase <= PROLOGUE;
                    end
                end
                default: begin
                    phase <= PROLOGUE;
                end
            endcase
            // Centre position of the window being emitted
            if (emit) begin
                if (col == last_col) begin
                    col <= '0;
                    row <= last_pad ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // Taps come from the buffer before this shift
    always_ff @(posedge clock) begin
        if (shift) begin
            shift_reg <= {shift_reg[1:buf_len-1], shift_data};
        end
        if (emit) begin
            win_center <= shift_reg[mid+1];
            win_neighbors <= {shift_reg[2*mid+2], shift_reg[2*mid+1], shift_reg[2*mid],
                              shift_reg[mid+2], shift_reg[mid],
                              shift_reg[2], shift_reg[1], shift_reg[0]};
            win_row <= row;
            win_col <= col;
        end
    end

endmodule

/* source/strength_classify.sv */
`timescale 1ns/100ps
`include "edge_settings.svh"

module strength_classify (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   pipe_enable,
    input  logic                   win_valid,
    input  pixel_pkg::pixel_t      win_center,
    output logic                   class_valid,
    output pixel_pkg::strength_t   center_strength,
    output pixel_pkg::pixel_t      center_value
);
    import pixel_pkg::*;

    localparam pixel_t high_limit = pixel_t'(`EDGE_HIGH_THRESHOLD);
    localparam pixel_t low_limit = pixel_t'(`EDGE_LOW_THRESHOLD);

    strength_t rating;

    // A value equal to a limit does not pass it
    always_comb begin
        if (win_center > high_limit) begin
            rating = STRENGTH_STRONG;
        end else if (win_center > low_limit) begin
            rating = STRENGTH_WEAK;
        end else begin
            rating = STRENGTH_NONE;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            class_valid <= 1'b0;
        end else if (pipe_enable) begin
            class_valid <= win_valid;
        end
    end

    // Value travels with its rating so the merge can pass it on
    always_ff @(posedge clock) begin
        if (pipe_enable && win_valid) begin
            center_strength <= rating;
            center_value <= win_center;
        end
    end

endmodule

/* src.f */
+incdir+source
source/pixel_pkg.sv
source/frame_pkg.sv
source/pixel_window.sv
source/strength_classify.sv
source/neighbor_strength.sv
source/hysteresis_merge.sv
source/hysteresis_top.sv
bench/hysteresis_props.sv
bench/hysteresis_tb.sv
